//--- verilog/cv_pad_pkg.sv
`default_nettype none

package cv_pad_pkg;

	// ========================================================================
	// Report and controller structs
	// ========================================================================

	// One parsed port report from the low-latency pad link
	typedef struct packed {
		logic [31:0] buttons;
		// Left stick, centre near 128
		logic [7:0]  stick_x;
		logic [7:0]  stick_y;
		// Controller identity as reported by the adapter
		logic [7:0]  pad_type;
		logic        en;
	} llapi_pad_t;

	// Console joystick word, one bit per logical control
	typedef struct packed {
		logic       blue_tr;
		logic       purple_tr;
		// Index 0 to 9 is the digit itself
		logic [9:0] digit;
		logic       hash;
		logic       star;
		logic       fire2;
		logic       fire1;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} cv_joy_t;

	// Controller lines of one player, all active low
	typedef struct packed {
		logic [3:0] lines;
		logic       fire_n;
	} cv_ctrl_t;

	// ========================================================================
	// Controller type codes
	// ========================================================================

	localparam logic [7:0] PAD_COLECO_A  = 8'd1;
	localparam logic [7:0] PAD_COLECO_B  = 8'd34;
	localparam logic [7:0] PAD_JAGUAR    = 8'd11;
	localparam logic [7:0] PAD_NTT_A     = 8'd47;
	localparam logic [7:0] PAD_NTT_B     = 8'd27;
	localparam logic [7:0] PAD_ATARI5200 = 8'd6;
	// Adapter reports this with nothing plugged in
	localparam logic [7:0] PAD_NONE_HI   = 8'd255;

	// Keypad line codes as seen by the console
	localparam logic [3:0] KEY_0      = 4'b0011;
	localparam logic [3:0] KEY_1      = 4'b1110;
	localparam logic [3:0] KEY_2      = 4'b1101;
	localparam logic [3:0] KEY_3      = 4'b0110;
	localparam logic [3:0] KEY_4      = 4'b0001;
	localparam logic [3:0] KEY_5      = 4'b1001;
	localparam logic [3:0] KEY_6      = 4'b0111;
	localparam logic [3:0] KEY_7      = 4'b1100;
	localparam logic [3:0] KEY_8      = 4'b1000;
	localparam logic [3:0] KEY_9      = 4'b1011;
	localparam logic [3:0] KEY_STAR   = 4'b1010;
	localparam logic [3:0] KEY_HASH   = 4'b0101;
	localparam logic [3:0] KEY_PURPLE = 4'b0100;
	localparam logic [3:0] KEY_BLUE   = 4'b0010;
	localparam logic [3:0] KEY_NONE   = 4'b1111;

	// Fixed button positions in the report, HID id minus one
	localparam logic [4:0] BTN_FIRE1  = 5'd0;
	localparam logic [4:0] BTN_FIRE2  = 5'd1;
	localparam logic [4:0] BTN_START  = 5'd5;
	// Digits 1 to 9 follow on from here
	localparam logic [4:0] BTN_DIGIT1 = 5'd8;
	localparam logic [4:0] BTN_STAR   = 5'd17;
	localparam logic [4:0] BTN_DIGIT0 = 5'd18;
	localparam logic [4:0] BTN_HASH   = 5'd19;
	localparam logic [4:0] BTN_RIGHT  = 5'd24;
	localparam logic [4:0] BTN_LEFT   = 5'd25;
	localparam logic [4:0] BTN_DOWN   = 5'd26;
	localparam logic [4:0] BTN_UP     = 5'd27;

endpackage

`default_nettype wire

//--- verilog/llapi_status.sv
`default_nettype none
`timescale 1ns/100ps

module llapi_status (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire cv_pad_pkg::llapi_pad_t pad_a_i,
	input  wire cv_pad_pkg::llapi_pad_t pad_b_i,
	output logic [1:0]                  present_o,
	output logic                        osd_req_o
);
	import cv_pad_pkg::*;

	// Both ports side by side, index 0 is port A
	llapi_pad_t [1:0] pad;

	// Sticky, set by the first nonzero button word
	logic [1:0] seen_q;
	// Type code names a real controller
	logic [1:0] type_ok;
	// Down + start + fire 1 held on that port
	logic [1:0] chord;

	assign pad = {pad_b_i, pad_a_i};

	// ========================================================================
	// Per-port decode
	// ========================================================================

	always_comb begin
		for (int p = 0; p < 2; p++) begin
			// Type 0 means Atari mode or empty, 255 means empty
			type_ok[p] = (pad[p].pad_type != 8'd0) && (pad[p].pad_type != PAD_NONE_HI);
			chord[p]   = pad[p].buttons[BTN_DOWN] &
				pad[p].buttons[BTN_START] &
				pad[p].buttons[BTN_FIRE1];
		end
	end

	// ========================================================================
	// Registered presence and menu request
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			seen_q    <= 2'b00;
			present_o <= 2'b00;
			osd_req_o <= 1'b0;
		end else begin
			for (int p = 0; p < 2; p++) begin
				// Any press proves a pad is there
				if (|pad[p].buttons) begin
					seen_q[p] <= 1'b1;
				end
				// Seen flag adds one cycle on unidentified pads
				present_o[p] <= pad[p].en && (type_ok[p] || seen_q[p]);
			end
			// Either player may open the menu
			osd_req_o <= |chord;
		end
	end

endmodule

`default_nettype wire

//--- verilog/llapi_pad_mapper.sv
`default_nettype none
`timescale 1ns/100ps

module llapi_pad_mapper #(
	parameter int unsigned STICK_LOW  = 50,
	parameter int unsigned STICK_HIGH = 200
) (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire cv_pad_pkg::llapi_pad_t pad_i,
	input  wire                         present_i,
	output cv_pad_pkg::cv_joy_t         joy_o
);
	import cv_pad_pkg::*;

	// Button layouts
	localparam logic [1:0] LAY_COLECO = 2'd0;
	localparam logic [1:0] LAY_JAGUAR = 2'd1;
	localparam logic [1:0] LAY_A5200  = 2'd2;
	// NTT and anything unknown
	localparam logic [1:0] LAY_NTT    = 2'd3;

	logic [1:0]  layout;
	logic [31:0] btn;
	logic        stk_right;
	logic        stk_left;
	logic        stk_down;
	logic        stk_up;
	cv_joy_t     joy_d;

	assign btn = pad_i.buttons;

	// ========================================================================
	// Type decode
	// ========================================================================

	always_comb begin
		case (pad_i.pad_type)
			PAD_COLECO_A, PAD_COLECO_B: layout = LAY_COLECO;
			PAD_JAGUAR:                 layout = LAY_JAGUAR;
			PAD_ATARI5200:              layout = LAY_A5200;
			PAD_NTT_A, PAD_NTT_B:       layout = LAY_NTT;
			// Unknown pads get the SNES-style layout
			default:                    layout = LAY_NTT;
		endcase
	end

	// Analog stick to digital, outside the dead band
	assign stk_right = (pad_i.stick_x > STICK_HIGH);
	assign stk_left  = (pad_i.stick_x < STICK_LOW);
	assign stk_down  = (pad_i.stick_y > STICK_HIGH);
	assign stk_up    = (pad_i.stick_y < STICK_LOW);

	// ========================================================================
	// Joystick word build
	// ========================================================================

	always_comb begin
		joy_d = '0;

		// Keypad positions are common to every type
		joy_d.digit[0] = btn[BTN_DIGIT0];
		for (int d = 1; d < 10; d++) begin
			joy_d.digit[d] = btn[BTN_DIGIT1 + d - 1];
		end
		joy_d.star = btn[BTN_STAR];
		joy_d.hash = btn[BTN_HASH];

		// D-pad from buttons unless the stick takes over below
		joy_d.up    = btn[BTN_UP];
		joy_d.down  = btn[BTN_DOWN];
		joy_d.left  = btn[BTN_LEFT];
		joy_d.right = btn[BTN_RIGHT];

		case (layout)
			LAY_COLECO: begin
				joy_d.purple_tr = btn[2];
				joy_d.blue_tr   = btn[3];
				joy_d.fire1     = btn[BTN_FIRE1];
				joy_d.fire2     = btn[BTN_FIRE2];
			end
			LAY_JAGUAR: begin
				// C and B face buttons as the triggers
				joy_d.purple_tr = btn[5];
				joy_d.blue_tr   = btn[4];
				joy_d.fire1     = btn[BTN_FIRE1];
				joy_d.fire2     = btn[7];
			end
			LAY_A5200: begin
				// No trigger buttons on this pad
				joy_d.fire1 = btn[BTN_FIRE1];
				joy_d.fire2 = btn[BTN_FIRE2];
				joy_d.up    = stk_up;
				joy_d.down  = stk_down;
				joy_d.left  = stk_left;
				joy_d.right = stk_right;
			end
			default: begin
				joy_d.purple_tr = btn[2];
				joy_d.blue_tr   = btn[3];
				// Shoulder buttons double the fires
				joy_d.fire1     = btn[BTN_FIRE1] | btn[6];
				joy_d.fire2     = btn[BTN_FIRE2] | btn[7];
			end
		endcase
	end

	// Absent port reads as nothing held
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			joy_o <= '0;
		end else if (present_i) begin
			joy_o <= joy_d;
		end else begin
			joy_o <= '0;
		end
	end

endmodule

`default_nettype wire

//--- verilog/cv_ctrl_encoder.sv
`default_nettype none
`timescale 1ns/100ps

module cv_ctrl_encoder (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire cv_pad_pkg::cv_joy_t joy_a_i,
	input  wire cv_pad_pkg::cv_joy_t joy_b_i,
	input  wire                      swap_i,
	// Per-player strobes from the console, active low
	input  wire [1:0]                keypad_sel_n_i,
	input  wire [1:0]                stick_sel_n_i,
	output cv_pad_pkg::cv_ctrl_t [1:0] ctrl_o
);
	import cv_pad_pkg::*;

	// Line code per keypad input, in priority order
	localparam logic [3:0] KEY_TAB [14] = '{
		KEY_0, KEY_1, KEY_2, KEY_3, KEY_4,
		KEY_5, KEY_6, KEY_7, KEY_8, KEY_9,
		KEY_STAR, KEY_HASH, KEY_PURPLE, KEY_BLUE
	};

	// Words after the player swap
	cv_joy_t [1:0]  player;
	cv_ctrl_t [1:0] ctrl_d;

	// ========================================================================
	// Keypad priority encoder
	// ========================================================================

	// Lowest index held wins, nothing held gives all ones
	function automatic logic [3:0] key_code(input cv_joy_t j);
		logic [13:0] held;
		logic [3:0]  code;

		// Digit 0 at bit 0, blue trigger at the top
		held = {j.blue_tr, j.purple_tr, j.hash, j.star, j.digit};
		code = KEY_NONE;
		// Walk from lowest priority so the winner writes last
		for (int k = 13; k >= 0; k--) begin
			if (held[k]) begin
				code = KEY_TAB[k];
			end
		end
		return code;
	endfunction

	// Player swap
	assign player[0] = swap_i ? joy_b_i : joy_a_i;
	assign player[1] = swap_i ? joy_a_i : joy_b_i;

	// ========================================================================
	// Line encoding
	// ========================================================================

	always_comb begin
		logic [3:0] kp_lines;
		logic [3:0] js_lines;
		logic       kp_fire;
		logic       js_fire;

		for (int p = 0; p < 2; p++) begin
			// Deselected halves float high
			kp_lines = 4'b1111;
			js_lines = 4'b1111;
			kp_fire  = 1'b1;
			js_fire  = 1'b1;

			// Keypad half carries the right fire
			if (!keypad_sel_n_i[p]) begin
				kp_lines = key_code(player[p]);
				kp_fire  = ~player[p].fire2;
			end

			// Joystick half, up on the top line
			if (!stick_sel_n_i[p]) begin
				js_lines = ~{player[p].up, player[p].down, player[p].left, player[p].right};
				js_fire  = ~player[p].fire1;
			end

			// Open-collector style merge of both halves
			ctrl_d[p].lines  = kp_lines & js_lines;
			ctrl_d[p].fire_n = kp_fire & js_fire;
		end
	end

	// All lines idle high out of reset
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ctrl_o <= '1;
		end else begin
			ctrl_o <= ctrl_d;
		end
	end

endmodule

`default_nettype wire

//--- verilog/coleco_pad_bridge.sv
`default_nettype none
`timescale 1ns/100ps

module coleco_pad_bridge #(
	// Stick dead band for 5200 pads
	parameter int unsigned STICK_LOW  = 50,
	parameter int unsigned STICK_HIGH = 200
) (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire cv_pad_pkg::llapi_pad_t pad_a_i,
	input  wire cv_pad_pkg::llapi_pad_t pad_b_i,
	input  wire                         swap_i,
	input  wire [1:0]                   keypad_sel_n_i,
	input  wire [1:0]                   stick_sel_n_i,
	output cv_pad_pkg::cv_ctrl_t [1:0]  ctrl_o,
	output logic                        osd_req_o
);
	import cv_pad_pkg::*;

	// Bit 0 is port A
	logic [1:0] present;
	cv_joy_t    joy_a;
	cv_joy_t    joy_b;

	// Presence and menu chord
	llapi_status u_status (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.pad_a_i   (pad_a_i),
		.pad_b_i   (pad_b_i),
		.present_o (present),
		.osd_req_o (osd_req_o)
	);

	// Port A remap
	llapi_pad_mapper #(
		.STICK_LOW  (STICK_LOW),
		.STICK_HIGH (STICK_HIGH)
	) u_map_a (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.pad_i     (pad_a_i),
		.present_i (present[0]),
		.joy_o     (joy_a)
	);

	// Port B remap
	llapi_pad_mapper #(
		.STICK_LOW  (STICK_LOW),
		.STICK_HIGH (STICK_HIGH)
	) u_map_b (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.pad_i     (pad_b_i),
		.present_i (present[1]),
		.joy_o     (joy_b)
	);

	// Swap and console line encoding
	cv_ctrl_encoder u_encoder (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.joy_a_i        (joy_a),
		.joy_b_i        (joy_b),
		.swap_i         (swap_i),
		.keypad_sel_n_i (keypad_sel_n_i),
		.stick_sel_n_i  (stick_sel_n_i),
		.ctrl_o         (ctrl_o)
	);

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_o,
	output logic reset_o
);

	// Free-running system clock
	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk_o = ~clk_o;
		end
	end

	// Held from time zero, released on a rising edge
	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

`default_nettype wire

//--- dv/pad_scoreboard.sv
`default_nettype none
`timescale 1ns/100ps

module pad_scoreboard (
	input  wire                             clk_sys,
	input  wire cv_pad_pkg::cv_ctrl_t [1:0] ctrl_i,
	input  wire                             osd_req_i,
	output int                              fail_tests_o
);
	import cv_pad_pkg::*;

	int test_count;
	int pass_count;

	initial begin
		test_count   = 0;
		pass_count   = 0;
		fail_tests_o = 0;
	end

	// Falling edge, clear of register updates
	task automatic check_row(input string name, input cv_ctrl_t [1:0] exp_ctrl,
			input logic exp_osd);
		int errs;

		errs = 0;
		@(negedge clk_sys);
		for (int p = 0; p < 2; p++) begin
			if (ctrl_i[p].lines !== exp_ctrl[p].lines) begin
				$display("mismatch at %0d ns: %0s player %0d lines %b, expected %b",
					$time, name, p, ctrl_i[p].lines, exp_ctrl[p].lines);
				errs++;
			end
			if (ctrl_i[p].fire_n !== exp_ctrl[p].fire_n) begin
				$display("mismatch at %0d ns: %0s player %0d fire_n %b, expected %b",
					$time, name, p, ctrl_i[p].fire_n, exp_ctrl[p].fire_n);
				errs++;
			end
		end
		if (osd_req_i !== exp_osd) begin
			$display("mismatch at %0d ns: %0s menu request %b, expected %b",
				$time, name, osd_req_i, exp_osd);
			errs++;
		end

		test_count++;
		if (errs == 0) begin
			pass_count++;
			$display("test %0s: ok", name);
		end else begin
			fail_tests_o++;
			$display("test %0s: failed with %0d wrong values", name, errs);
		end
	endtask

	task automatic print_summary(input int assert_fails);
		$display("summary: %0d tests, %0d passed, %0d failed, %0d assertion failures",
			test_count, pass_count, fail_tests_o, assert_fails);
	endtask

endmodule

`default_nettype wire

//--- dv/coleco_pad_bridge_checker.sv
`default_nettype none
`timescale 1ns/100ps

module coleco_pad_bridge_checker (
	input wire                             clk_sys,
	input wire                             reset,
	input wire cv_pad_pkg::llapi_pad_t     pad_a_i,
	input wire cv_pad_pkg::llapi_pad_t     pad_b_i,
	input wire [1:0]                       keypad_sel_n_i,
	input wire [1:0]                       stick_sel_n_i,
	input wire cv_pad_pkg::cv_ctrl_t [1:0] ctrl_i,
	input wire                             osd_req_i
);
	import cv_pad_pkg::*;

	// Count of failed assertions
	int   fail_count = 0;
	logic chord;

	// Down + start + fire 1 on either port
	assign chord = (pad_a_i.buttons[BTN_DOWN] & pad_a_i.buttons[BTN_START] &
		pad_a_i.buttons[BTN_FIRE1]) | (pad_b_i.buttons[BTN_DOWN] &
		pad_b_i.buttons[BTN_START] & pad_b_i.buttons[BTN_FIRE1]);

	// Idle outputs once reset has been seen
	reset_idle: assert property (@(posedge clk_sys)
		reset |=> ((ctrl_i == '1) && !osd_req_i))
		else begin
			$error("outputs active while reset is asserted");
			fail_count++;
		end

	// Player with both strobes high floats all ones
	player0_idle: assert property (@(posedge clk_sys) disable iff (reset)
		(keypad_sel_n_i[0] && stick_sel_n_i[0]) |=> (ctrl_i[0] == '1))
		else begin
			$error("deselected player 0 drives its lines");
			fail_count++;
		end

	player1_idle: assert property (@(posedge clk_sys) disable iff (reset)
		(keypad_sel_n_i[1] && stick_sel_n_i[1]) |=> (ctrl_i[1] == '1))
		else begin
			$error("deselected player 1 drives its lines");
			fail_count++;
		end

	// Menu request one edge behind the chord
	osd_follows: assert property (@(posedge clk_sys) disable iff (reset)
		1'b1 |=> (osd_req_i == $past(chord)))
		else begin
			$error("menu request does not follow the button chord");
			fail_count++;
		end

endmodule

bind coleco_pad_bridge coleco_pad_bridge_checker u_checker (
	.clk_sys        (clk_sys),
	.reset          (reset),
	.pad_a_i        (pad_a_i),
	.pad_b_i        (pad_b_i),
	.keypad_sel_n_i (keypad_sel_n_i),
	.stick_sel_n_i  (stick_sel_n_i),
	.ctrl_i         (ctrl_o),
	.osd_req_i      (osd_req_o)
);

`default_nettype wire

//--- dv/coleco_pad_bridge_tb.sv
`default_nettype none
`timescale 1ns/100ps

module coleco_pad_bridge_tb;
	import cv_pad_pkg::*;

	typedef cv_ctrl_t [1:0] ctrl_pair_t;

	localparam int STICK_LOW       = 50;
	localparam int STICK_HIGH      = 200;
	// Seen-flag path takes four edges
	localparam int CHECK_DELAY     = 4;
	localparam int RESET_LIMIT     = 20;
	localparam int WATCHDOG_CYCLES = 1000;
	// Active-low strobes for both players
	localparam logic [1:0] SEL_ON  = 2'b00;
	localparam logic [1:0] SEL_OFF = 2'b11;

	logic       clk_sys;
	logic       reset;
	llapi_pad_t pad_a;
	llapi_pad_t pad_b;
	logic       swap;
	logic [1:0] keypad_sel_n;
	logic [1:0] stick_sel_n;
	ctrl_pair_t ctrl;
	logic       osd_req;
	int         fail_tests;
	integer     seed;

	// ========================================================================
	// Stimulus table with one index per row
	// ========================================================================

	string      tab_name [$];
	llapi_pad_t tab_pad_a [$];
	llapi_pad_t tab_pad_b [$];
	logic       tab_swap [$];
	logic [1:0] tab_kp_sel [$];
	logic [1:0] tab_st_sel [$];
	ctrl_pair_t tab_ctrl [$];
	logic       tab_osd [$];

	tb_clock_gen #(
		.PERIOD_NS    (40),
		.RESET_CYCLES (8)
	) u_clock (
		.clk_o   (clk_sys),
		.reset_o (reset)
	);

	coleco_pad_bridge #(
		.STICK_LOW  (STICK_LOW),
		.STICK_HIGH (STICK_HIGH)
	) UUT (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.pad_a_i        (pad_a),
		.pad_b_i        (pad_b),
		.swap_i         (swap),
		.keypad_sel_n_i (keypad_sel_n),
		.stick_sel_n_i  (stick_sel_n),
		.ctrl_o         (ctrl),
		.osd_req_o      (osd_req)
	);

	pad_scoreboard u_scoreboard (
		.clk_sys      (clk_sys),
		.ctrl_i       (ctrl),
		.osd_req_i    (osd_req),
		.fail_tests_o (fail_tests)
	);

	function automatic logic [31:0] btn_bit(input logic [4:0] idx);
		return 32'd1 << idx;
	endfunction

	function automatic logic [7:0] filler_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// Stick bytes are filler unless the pad is a 5200
	function automatic llapi_pad_t make_pad(input logic [7:0] pad_type,
			input logic [31:0] buttons, input logic en);
		llapi_pad_t p;
		p.buttons  = buttons;
		p.stick_x  = filler_byte();
		p.stick_y  = filler_byte();
		p.pad_type = pad_type;
		p.en       = en;
		return p;
	endfunction

	function automatic llapi_pad_t stick_pad(input logic [7:0] x, input logic [7:0] y,
			input logic [31:0] buttons);
		llapi_pad_t p;
		p = make_pad(PAD_ATARI5200, buttons, 1'b1);
		p.stick_x = x;
		p.stick_y = y;
		return p;
	endfunction

	function automatic ctrl_pair_t expect_lines(input logic [3:0] lines0, input logic fire0,
			input logic [3:0] lines1, input logic fire1);
		ctrl_pair_t c;
		c[0].lines  = lines0;
		c[0].fire_n = fire0;
		c[1].lines  = lines1;
		c[1].fire_n = fire1;
		return c;
	endfunction

	task automatic add_row(input string name, input llapi_pad_t pa, input llapi_pad_t pb,
			input logic sw, input logic [1:0] kp, input logic [1:0] st,
			input ctrl_pair_t exp_ctrl, input logic exp_osd);
		tab_name.push_back(name);
		tab_pad_a.push_back(pa);
		tab_pad_b.push_back(pb);
		tab_swap.push_back(sw);
		tab_kp_sel.push_back(kp);
		tab_st_sel.push_back(st);
		tab_ctrl.push_back(exp_ctrl);
		tab_osd.push_back(exp_osd);
	endtask

	// ========================================================================
	// Row order matters for the sticky seen flags
	// ========================================================================

	task automatic build_table();
		llapi_pad_t idle;
		ctrl_pair_t all_off;

		idle    = make_pad(PAD_NONE_HI, 32'd0, 1'b0);
		all_off = expect_lines(KEY_NONE, 1'b1, KEY_NONE, 1'b1);

		// Presence
		add_row("absent_type0", make_pad(8'd0, 32'd0, 1'b1), make_pad(8'd0, 32'd0, 1'b1),
			1'b0, SEL_OFF, SEL_ON, all_off, 1'b0);
		add_row("enable_low", make_pad(PAD_COLECO_A, btn_bit(BTN_UP) | btn_bit(BTN_FIRE1), 1'b0),
			idle, 1'b0, SEL_OFF, SEL_ON, all_off, 1'b0);
		// Up on lines 0111
		add_row("seen_type0", idle, make_pad(8'd0, btn_bit(BTN_UP), 1'b1),
			1'b0, SEL_OFF, SEL_ON, expect_lines(4'b1111, 1'b1, 4'b0111, 1'b1), 1'b0);

		// Coleco keypad
		add_row("coleco_digit0_priority", make_pad(PAD_COLECO_A,
			btn_bit(BTN_DIGIT1) | btn_bit(BTN_DIGIT0) | btn_bit(BTN_FIRE2), 1'b1),
			idle, 1'b0, SEL_ON, SEL_OFF, expect_lines(KEY_0, 1'b0, KEY_NONE, 1'b1), 1'b0);
		add_row("coleco_b_digit5", make_pad(PAD_COLECO_B, btn_bit(BTN_DIGIT1 + 5'd4), 1'b1),
			idle, 1'b0, SEL_ON, SEL_OFF, expect_lines(KEY_5, 1'b1, KEY_NONE, 1'b1), 1'b0);
		add_row("coleco_purple", make_pad(PAD_COLECO_A, btn_bit(5'd2) | btn_bit(5'd3), 1'b1),
			idle, 1'b0, SEL_ON, SEL_OFF, expect_lines(KEY_PURPLE, 1'b1, KEY_NONE, 1'b1), 1'b0);

		// Jaguar and NTT fires
		add_row("jaguar_fire2_joystick", make_pad(PAD_JAGUAR, btn_bit(5'd7), 1'b1),
			idle, 1'b0, SEL_OFF, SEL_ON, all_off, 1'b0);
		add_row("jaguar_fire2_keypad", make_pad(PAD_JAGUAR, btn_bit(5'd7), 1'b1),
			idle, 1'b0, SEL_ON, SEL_OFF, expect_lines(KEY_NONE, 1'b0, KEY_NONE, 1'b1), 1'b0);
		add_row("ntt_fire1_joystick", make_pad(PAD_NTT_A, btn_bit(5'd6), 1'b1),
			idle, 1'b0, SEL_OFF, SEL_ON, expect_lines(4'b1111, 1'b0, 4'b1111, 1'b1), 1'b0);
		add_row("ntt_dpad_up", make_pad(PAD_NTT_B, btn_bit(BTN_UP), 1'b1),
			idle, 1'b0, SEL_OFF, SEL_ON, expect_lines(4'b0111, 1'b1, 4'b1111, 1'b1), 1'b0);

		// Right and up on the 5200 stick give 0110
		add_row("a5200_right_up", stick_pad(8'd210, 8'd40, 32'd0),
			idle, 1'b0, SEL_OFF, SEL_ON, expect_lines(4'b0110, 1'b1, 4'b1111, 1'b1), 1'b0);
		add_row("a5200_centre", stick_pad(8'd120, 8'd128, 32'd0),
			idle, 1'b0, SEL_OFF, SEL_ON, all_off, 1'b0);
		add_row("a5200_no_triggers", stick_pad(8'd128, 8'd128, btn_bit(5'd2) | btn_bit(5'd3)),
			idle, 1'b0, SEL_ON, SEL_OFF, all_off, 1'b0);

		// Swap with digit 3 on A and digit 7 on B
		add_row("swap_keypad", make_pad(PAD_COLECO_A, btn_bit(BTN_DIGIT1 + 5'd2), 1'b1),
			make_pad(PAD_COLECO_B, btn_bit(BTN_DIGIT1 + 5'd6), 1'b1),
			1'b1, SEL_ON, SEL_OFF, expect_lines(KEY_7, 1'b1, KEY_3, 1'b1), 1'b0);

		// Menu chord on port B with both players deselected
		// Swapped here so player 0 also carries a live word
		add_row("menu_chord_b", idle, make_pad(PAD_COLECO_A,
			btn_bit(BTN_DOWN) | btn_bit(BTN_START) | btn_bit(BTN_FIRE1), 1'b1),
			1'b1, SEL_OFF, SEL_OFF, all_off, 1'b1);
		add_row("menu_no_start", idle, make_pad(PAD_COLECO_A,
			btn_bit(BTN_DOWN) | btn_bit(BTN_FIRE1), 1'b1),
			1'b0, SEL_OFF, SEL_OFF, all_off, 1'b0);
		add_row("menu_no_down", idle, make_pad(PAD_COLECO_A,
			btn_bit(BTN_START) | btn_bit(BTN_FIRE1), 1'b1),
			1'b0, SEL_OFF, SEL_OFF, all_off, 1'b0);
		add_row("menu_no_fire1", idle, make_pad(PAD_COLECO_A,
			btn_bit(BTN_DOWN) | btn_bit(BTN_START), 1'b1),
			1'b0, SEL_OFF, SEL_OFF, all_off, 1'b0);
	endtask

	// Drive on a rising edge and check after the longest path
	task automatic apply_rows();
		int cycles;

		for (int r = 0; r < tab_name.size(); r++) begin
			@(posedge clk_sys);
			pad_a        <= tab_pad_a[r];
			pad_b        <= tab_pad_b[r];
			swap         <= tab_swap[r];
			keypad_sel_n <= tab_kp_sel[r];
			stick_sel_n  <= tab_st_sel[r];
			cycles = 0;
			while (cycles < CHECK_DELAY) begin
				@(posedge clk_sys);
				cycles++;
			end
			u_scoreboard.check_row(tab_name[r], tab_ctrl[r], tab_osd[r]);
		end
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin : main
		int cycles;

		seed = 26;
		pad_a        <= make_pad(PAD_NONE_HI, 32'd0, 1'b0);
		pad_b        <= make_pad(PAD_NONE_HI, 32'd0, 1'b0);
		swap         <= 1'b0;
		keypad_sel_n <= SEL_OFF;
		stick_sel_n  <= SEL_OFF;
		build_table();

		cycles = 0;
		while (reset !== 1'b0 && cycles < RESET_LIMIT) begin
			@(posedge clk_sys);
			cycles++;
		end

		if (reset !== 1'b0) begin
			$display("timeout: reset still asserted after %0d cycles", RESET_LIMIT);
			$display(">>> FAIL");
			$finish;
		end else begin
			apply_rows();
			u_scoreboard.print_summary(UUT.u_checker.fail_count);
			if (fail_tests == 0 && UUT.u_checker.fail_count == 0) begin
				$display(">>> PASS");
			end else begin
				$display(">>> FAIL");
			end
			$finish;
		end
	end

	// Hard stop for a stuck run
	initial begin : watchdog
		int cycles;

		cycles = 0;
		while (cycles < WATCHDOG_CYCLES) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("timeout: run did not complete within %0d cycles", WATCHDOG_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- coleco_pad_bridge.f
verilog/cv_pad_pkg.sv
verilog/llapi_status.sv
verilog/llapi_pad_mapper.sv
verilog/cv_ctrl_encoder.sv
verilog/coleco_pad_bridge.sv
dv/tb_clock_gen.sv
dv/pad_scoreboard.sv
dv/coleco_pad_bridge_checker.sv
dv/coleco_pad_bridge_tb.sv

//--- Bender.yml
package:
  name: coleco_pad_bridge

sources:
  # Design, package first
  - verilog/cv_pad_pkg.sv
  - verilog/llapi_status.sv
  - verilog/llapi_pad_mapper.sv
  - verilog/cv_ctrl_encoder.sv
  - verilog/coleco_pad_bridge.sv

  # Testbench
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/pad_scoreboard.sv
      - dv/coleco_pad_bridge_checker.sv
      - dv/coleco_pad_bridge_tb.sv
